// ==== common/tunnel_pkg.sv ====
`default_nettype none

package tunnel_pkg;

  // Bits per byte lane, used to turn bit widths into tkeep widths
  localparam int BYTE_BITS = 8;

  // Default stream word and header widths for the tunnel
  localparam int DATA_WIDTH_DEF = 128;
  localparam int HDR_WIDTH_DEF  = 64;

  // Side-band widths carried with every beat
  localparam int DEST_WIDTH_DEF = 8;
  localparam int USER_WIDTH_DEF = 8;

  // Entries in the link FIFO between the adder and the remover
  localparam int FIFO_DEPTH_DEF = 8;

endpackage

`default_nettype wire

// ==== header_adder/header_adder.sv ====
`timescale 1ns/1ns
`default_nettype none

module header_adder #(
  parameter int DATA_WIDTH = tunnel_pkg::DATA_WIDTH_DEF,
  parameter int HDR_WIDTH  = tunnel_pkg::HDR_WIDTH_DEF,
  parameter int DEST_WIDTH = tunnel_pkg::DEST_WIDTH_DEF,
  parameter int USER_WIDTH = tunnel_pkg::USER_WIDTH_DEF
) (
  input  wire                                        clk,
  input  wire                                        rst,

  input  wire  [DATA_WIDTH-1:0]                      s_tdata,
  input  wire  [DATA_WIDTH/tunnel_pkg::BYTE_BITS-1:0] s_tkeep,
  input  wire  [DEST_WIDTH-1:0]                      s_tdest,
  input  wire  [USER_WIDTH-1:0]                      s_tuser,
  input  wire                                        s_tlast,
  input  wire                                        s_tvalid,
  output logic                                       s_tready,

  input  wire  [HDR_WIDTH-1:0]                       header,
  input  wire                                        header_valid,
  output logic                                       header_ready,

  output logic [DATA_WIDTH-1:0]                      m_tdata,
  output logic [DATA_WIDTH/tunnel_pkg::BYTE_BITS-1:0] m_tkeep,
  output logic [DEST_WIDTH-1:0]                      m_tdest,
  output logic [USER_WIDTH-1:0]                      m_tuser,
  output logic                                       m_tlast,
  output logic                                       m_tvalid,
  input  wire                                        m_tready
);
  import tunnel_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / BYTE_BITS;
  localparam int HDR_STRB   = HDR_WIDTH / BYTE_BITS;
  localparam int LOW_WIDTH  = DATA_WIDTH - HDR_WIDTH;
  localparam int LOW_STRB   = STRB_WIDTH - HDR_STRB;

  // First beat carries the header, the tail beat carries spilled bytes only
  localparam logic [1:0] ST_HDR = 2'd0;
  localparam logic [1:0] ST_MID = 2'd1;
  localparam logic [1:0] ST_LST = 2'd2;

  logic [1:0]            state;
  logic [HDR_WIDTH-1:0]  rest_tdata;
  logic [HDR_STRB-1:0]   rest_tkeep;
  logic [DEST_WIDTH-1:0] tdest_r;
  logic [USER_WIDTH-1:0] tuser_r;
  logic                  spill;
  logic                  first_ok;
  logic                  s_fire;

  // Bytes in the top HDR_STRB lanes do not fit in the shifted word
  assign spill = |s_tkeep[STRB_WIDTH-1:LOW_STRB];

  // Header and first data beat move together, so both must be present
  assign first_ok     = s_tvalid && header_valid && m_tready;
  assign header_ready = (state == ST_HDR) && first_ok;
  assign s_tready     = (state == ST_HDR) ? first_ok :
                        (state == ST_MID) ? m_tready : 1'b0;
  assign s_fire       = s_tvalid && s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_HDR;
    end else begin
      case (state)
        ST_HDR, ST_MID: begin
          if (s_fire) begin
            if (s_tlast) begin
              state <= spill ? ST_LST : ST_HDR;
            end else begin
              state <= ST_MID;
            end
          end
        end
        ST_LST: begin
          if (m_tready) begin
            state <= ST_HDR;
          end
        end
        default: state <= ST_HDR;
      endcase
    end
  end

  // The upper part of every accepted word moves into the next output beat
  always_ff @(posedge clk) begin
    if (s_fire) begin
      rest_tdata <= s_tdata[DATA_WIDTH-1:LOW_WIDTH];
      rest_tkeep <= s_tkeep[STRB_WIDTH-1:LOW_STRB];
    end
    if (s_fire && (state == ST_HDR)) begin
      tdest_r <= s_tdest;
      tuser_r <= s_tuser;
    end
  end

  always_comb begin
    m_tvalid = 1'b0;
    m_tdata  = {s_tdata[LOW_WIDTH-1:0], rest_tdata};
    m_tkeep  = {s_tkeep[LOW_STRB-1:0], rest_tkeep};
    m_tdest  = tdest_r;
    m_tuser  = tuser_r;
    m_tlast  = s_tlast && !spill;
    case (state)
      ST_HDR: begin
        m_tvalid = s_tvalid && header_valid;
        m_tdata  = {s_tdata[LOW_WIDTH-1:0], header};
        m_tkeep  = {s_tkeep[LOW_STRB-1:0], {HDR_STRB{1'b1}}};
        m_tdest  = s_tdest;
        m_tuser  = s_tuser;
      end
      ST_MID: begin
        m_tvalid = s_tvalid;
      end
      ST_LST: begin
        m_tvalid = 1'b1;
        m_tdata  = {{LOW_WIDTH{1'b0}}, rest_tdata};
        m_tkeep  = {{LOW_STRB{1'b0}}, rest_tkeep};
        m_tlast  = 1'b1;
      end
      default: m_tvalid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== header_remover/header_remover.sv ====
`timescale 1ns/1ns
`default_nettype none

module header_remover #(
  parameter int DATA_WIDTH = tunnel_pkg::DATA_WIDTH_DEF,
  parameter int HDR_WIDTH  = tunnel_pkg::HDR_WIDTH_DEF,
  parameter int DEST_WIDTH = tunnel_pkg::DEST_WIDTH_DEF,
  parameter int USER_WIDTH = tunnel_pkg::USER_WIDTH_DEF
) (
  input  wire                                        clk,
  input  wire                                        rst,

  input  wire  [DATA_WIDTH-1:0]                      s_tdata,
  input  wire  [DATA_WIDTH/tunnel_pkg::BYTE_BITS-1:0] s_tkeep,
  input  wire  [DEST_WIDTH-1:0]                      s_tdest,
  input  wire  [USER_WIDTH-1:0]                      s_tuser,
  input  wire                                        s_tlast,
  input  wire                                        s_tvalid,
  output logic                                       s_tready,

  // Valid on every beat where m_tvalid is high
  output logic [HDR_WIDTH-1:0]                       header,

  output logic [DATA_WIDTH-1:0]                      m_tdata,
  output logic [DATA_WIDTH/tunnel_pkg::BYTE_BITS-1:0] m_tkeep,
  output logic [DEST_WIDTH-1:0]                      m_tdest,
  output logic [USER_WIDTH-1:0]                      m_tuser,
  output logic                                       m_tlast,
  output logic                                       m_tvalid,
  input  wire                                        m_tready
);
  import tunnel_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / BYTE_BITS;
  localparam int HDR_STRB   = HDR_WIDTH / BYTE_BITS;
  localparam int LOW_WIDTH  = DATA_WIDTH - HDR_WIDTH;
  localparam int LOW_STRB   = STRB_WIDTH - HDR_STRB;

  localparam logic [1:0] ST_HDR = 2'd0;
  localparam logic [1:0] ST_MID = 2'd1;
  localparam logic [1:0] ST_LST = 2'd2;

  logic [1:0]            state;
  logic [HDR_WIDTH-1:0]  header_r;
  logic [LOW_WIDTH-1:0]  rest_tdata;
  logic [LOW_STRB-1:0]   rest_tkeep;
  logic [DEST_WIDTH-1:0] tdest_r;
  logic [USER_WIDTH-1:0] tuser_r;
  logic                  spill;
  logic                  s_fire;

  // Bytes above the header lanes still have to go out after this beat
  assign spill = |s_tkeep[STRB_WIDTH-1:HDR_STRB];

  // A multi-beat first word is only stored, so it needs no output slot.
  // A single-beat packet goes straight out and waits for the sink.
  assign s_tready = (state == ST_HDR) ? (!s_tlast || m_tready) :
                    (state == ST_MID) ? m_tready : 1'b0;
  assign s_fire   = s_tvalid && s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_HDR;
    end else begin
      case (state)
        ST_HDR: begin
          if (s_fire && !s_tlast) begin
            state <= ST_MID;
          end
        end
        ST_MID: begin
          if (s_fire && s_tlast) begin
            state <= spill ? ST_LST : ST_HDR;
          end
        end
        ST_LST: begin
          if (m_tready) begin
            state <= ST_HDR;
          end
        end
        default: state <= ST_HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      rest_tdata <= s_tdata[DATA_WIDTH-1:HDR_WIDTH];
      rest_tkeep <= s_tkeep[STRB_WIDTH-1:HDR_STRB];
    end
    // Header and side-band are taken from the first beat only
    if (s_fire && (state == ST_HDR)) begin
      header_r <= s_tdata[HDR_WIDTH-1:0];
      tdest_r  <= s_tdest;
      tuser_r  <= s_tuser;
    end
  end

  assign header = (state == ST_HDR) ? s_tdata[HDR_WIDTH-1:0] : header_r;

  always_comb begin
    m_tvalid = 1'b0;
    m_tdata  = {s_tdata[HDR_WIDTH-1:0], rest_tdata};
    m_tkeep  = {s_tkeep[HDR_STRB-1:0], rest_tkeep};
    m_tdest  = tdest_r;
    m_tuser  = tuser_r;
    m_tlast  = s_tlast && !spill;
    case (state)
      ST_HDR: begin
        // Only a packet that fits in one beat produces output here
        m_tvalid = s_tvalid && s_tlast;
        m_tdata  = {{HDR_WIDTH{1'b0}}, s_tdata[DATA_WIDTH-1:HDR_WIDTH]};
        m_tkeep  = {{HDR_STRB{1'b0}}, s_tkeep[STRB_WIDTH-1:HDR_STRB]};
        m_tdest  = s_tdest;
        m_tuser  = s_tuser;
        m_tlast  = 1'b1;
      end
      ST_MID: begin
        m_tvalid = s_tvalid;
      end
      ST_LST: begin
        m_tvalid = 1'b1;
        m_tdata  = {{HDR_WIDTH{1'b0}}, rest_tdata};
        m_tkeep  = {{HDR_STRB{1'b0}}, rest_tkeep};
        m_tlast  = 1'b1;
      end
      default: m_tvalid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/stream_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
  parameter int DATA_WIDTH = tunnel_pkg::DATA_WIDTH_DEF,
  parameter int DEST_WIDTH = tunnel_pkg::DEST_WIDTH_DEF,
  parameter int USER_WIDTH = tunnel_pkg::USER_WIDTH_DEF,
  parameter int FIFO_DEPTH = tunnel_pkg::FIFO_DEPTH_DEF
) (
  input  wire                                        clk,
  input  wire                                        rst,

  input  wire  [DATA_WIDTH-1:0]                      s_tdata,
  input  wire  [DATA_WIDTH/tunnel_pkg::BYTE_BITS-1:0] s_tkeep,
  input  wire  [DEST_WIDTH-1:0]                      s_tdest,
  input  wire  [USER_WIDTH-1:0]                      s_tuser,
  input  wire                                        s_tlast,
  input  wire                                        s_tvalid,
  output logic                                       s_tready,

  output logic [DATA_WIDTH-1:0]                      m_tdata,
  output logic [DATA_WIDTH/tunnel_pkg::BYTE_BITS-1:0] m_tkeep,
  output logic [DEST_WIDTH-1:0]                      m_tdest,
  output logic [USER_WIDTH-1:0]                      m_tuser,
  output logic                                       m_tlast,
  output logic                                       m_tvalid,
  input  wire                                        m_tready
);
  import tunnel_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / BYTE_BITS;
  localparam int BEAT_WIDTH = DATA_WIDTH + STRB_WIDTH + DEST_WIDTH + USER_WIDTH + 1;
  localparam int PTR_WIDTH  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH  = $clog2(FIFO_DEPTH + 1);

  logic [BEAT_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [CNT_WIDTH-1:0]  count;
  logic                  full;
  logic                  wr_en;
  logic                  rd_en;

  assign full     = (count == CNT_WIDTH'(FIFO_DEPTH));
  assign m_tvalid = (count != '0);
  // When full, a beat leaving this cycle frees the slot for the incoming one
  assign s_tready = !full || m_tready;
  assign wr_en    = s_tvalid && s_tready;
  assign rd_en    = m_tvalid && m_tready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {s_tlast, s_tuser, s_tdest, s_tkeep, s_tdata};
    end
  end

  assign {m_tlast, m_tuser, m_tdest, m_tkeep, m_tdata} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/header_tunnel.sv ====
`timescale 1ns/1ns
`default_nettype none

module header_tunnel #(
  parameter int DATA_WIDTH = tunnel_pkg::DATA_WIDTH_DEF,
  parameter int HDR_WIDTH  = tunnel_pkg::HDR_WIDTH_DEF,
  parameter int DEST_WIDTH = tunnel_pkg::DEST_WIDTH_DEF,
  parameter int USER_WIDTH = tunnel_pkg::USER_WIDTH_DEF,
  parameter int FIFO_DEPTH = tunnel_pkg::FIFO_DEPTH_DEF
) (
  input  wire                                        clk,
  input  wire                                        rst,

  input  wire  [DATA_WIDTH-1:0]                      in_tdata,
  input  wire  [DATA_WIDTH/tunnel_pkg::BYTE_BITS-1:0] in_tkeep,
  input  wire  [DEST_WIDTH-1:0]                      in_tdest,
  input  wire  [USER_WIDTH-1:0]                      in_tuser,
  input  wire                                        in_tlast,
  input  wire                                        in_tvalid,
  output logic                                       in_tready,
  input  wire  [HDR_WIDTH-1:0]                       in_header,
  input  wire                                        in_header_valid,
  output logic                                       in_header_ready,

  output logic [DATA_WIDTH-1:0]                      out_tdata,
  output logic [DATA_WIDTH/tunnel_pkg::BYTE_BITS-1:0] out_tkeep,
  output logic [DEST_WIDTH-1:0]                      out_tdest,
  output logic [USER_WIDTH-1:0]                      out_tuser,
  output logic                                       out_tlast,
  output logic                                       out_tvalid,
  input  wire                                        out_tready,
  output logic [HDR_WIDTH-1:0]                       out_header
);
  import tunnel_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / BYTE_BITS;

  // Framed packets on their way into the link FIFO
  logic [DATA_WIDTH-1:0] link_tdata;
  logic [STRB_WIDTH-1:0] link_tkeep;
  logic [DEST_WIDTH-1:0] link_tdest;
  logic [USER_WIDTH-1:0] link_tuser;
  logic                  link_tlast;
  logic                  link_tvalid;
  logic                  link_tready;

  // Framed packets leaving the FIFO toward the remover
  logic [DATA_WIDTH-1:0] tun_tdata;
  logic [STRB_WIDTH-1:0] tun_tkeep;
  logic [DEST_WIDTH-1:0] tun_tdest;
  logic [USER_WIDTH-1:0] tun_tuser;
  logic                  tun_tlast;
  logic                  tun_tvalid;
  logic                  tun_tready;

  header_adder #(
    .DATA_WIDTH (DATA_WIDTH),
    .HDR_WIDTH  (HDR_WIDTH),
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH)
  ) u_header_adder (
    .clk          (clk),
    .rst          (rst),
    .s_tdata      (in_tdata),
    .s_tkeep      (in_tkeep),
    .s_tdest      (in_tdest),
    .s_tuser      (in_tuser),
    .s_tlast      (in_tlast),
    .s_tvalid     (in_tvalid),
    .s_tready     (in_tready),
    .header       (in_header),
    .header_valid (in_header_valid),
    .header_ready (in_header_ready),
    .m_tdata      (link_tdata),
    .m_tkeep      (link_tkeep),
    .m_tdest      (link_tdest),
    .m_tuser      (link_tuser),
    .m_tlast      (link_tlast),
    .m_tvalid     (link_tvalid),
    .m_tready     (link_tready)
  );

  stream_fifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_stream_fifo (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (link_tdata),
    .s_tkeep  (link_tkeep),
    .s_tdest  (link_tdest),
    .s_tuser  (link_tuser),
    .s_tlast  (link_tlast),
    .s_tvalid (link_tvalid),
    .s_tready (link_tready),
    .m_tdata  (tun_tdata),
    .m_tkeep  (tun_tkeep),
    .m_tdest  (tun_tdest),
    .m_tuser  (tun_tuser),
    .m_tlast  (tun_tlast),
    .m_tvalid (tun_tvalid),
    .m_tready (tun_tready)
  );

  header_remover #(
    .DATA_WIDTH (DATA_WIDTH),
    .HDR_WIDTH  (HDR_WIDTH),
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH)
  ) u_header_remover (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (tun_tdata),
    .s_tkeep  (tun_tkeep),
    .s_tdest  (tun_tdest),
    .s_tuser  (tun_tuser),
    .s_tlast  (tun_tlast),
    .s_tvalid (tun_tvalid),
    .s_tready (tun_tready),
    .header   (out_header),
    .m_tdata  (out_tdata),
    .m_tkeep  (out_tkeep),
    .m_tdest  (out_tdest),
    .m_tuser  (out_tuser),
    .m_tlast  (out_tlast),
    .m_tvalid (out_tvalid),
    .m_tready (out_tready)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset is released on a rising edge so the DUT sees whole cycles of it
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== sim/header_tunnel_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module header_tunnel_properties #(
  parameter int DATA_WIDTH = tunnel_pkg::DATA_WIDTH_DEF,
  parameter int HDR_WIDTH  = tunnel_pkg::HDR_WIDTH_DEF
) (
  input wire                  clk,
  input wire                  rst,
  input wire [DATA_WIDTH-1:0] in_tdata,
  input wire                  in_tlast,
  input wire                  in_tvalid,
  input wire                  in_tready,
  input wire [HDR_WIDTH-1:0]  in_header,
  input wire                  in_header_valid,
  input wire                  in_header_ready,
  input wire [DATA_WIDTH-1:0] out_tdata,
  input wire                  out_tlast,
  input wire                  out_tvalid,
  input wire                  out_tready
);

  int fail_count = 0;

  // A stalled output beat is offered again unchanged
  out_hold: assert property (@(posedge clk) disable iff (rst)
    (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata) && $stable(out_tlast)))
  else begin
    $error("Output beat changed or vanished while out_tready was low");
    fail_count++;
  end

  // The source side keeps its beat until the tunnel takes it
  in_hold: assert property (@(posedge clk) disable iff (rst)
    (in_tvalid && !in_tready) |=> (in_tvalid && $stable(in_tdata) && $stable(in_tlast)))
  else begin
    $error("Input beat changed or vanished while in_tready was low");
    fail_count++;
  end

  hdr_hold: assert property (@(posedge clk) disable iff (rst)
    (in_header_valid && !in_header_ready) |=> (in_header_valid && $stable(in_header)))
  else begin
    $error("Header changed or vanished while in_header_ready was low");
    fail_count++;
  end

endmodule

bind header_tunnel header_tunnel_properties #(
  .DATA_WIDTH (DATA_WIDTH),
  .HDR_WIDTH  (HDR_WIDTH)
) u_tunnel_props (
  .clk             (clk),
  .rst             (rst),
  .in_tdata        (in_tdata),
  .in_tlast        (in_tlast),
  .in_tvalid       (in_tvalid),
  .in_tready       (in_tready),
  .in_header       (in_header),
  .in_header_valid (in_header_valid),
  .in_header_ready (in_header_ready),
  .out_tdata       (out_tdata),
  .out_tlast       (out_tlast),
  .out_tvalid      (out_tvalid),
  .out_tready      (out_tready)
);

`default_nettype wire

// ==== sim/header_tunnel_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module header_tunnel_tb;
  import tunnel_pkg::*;

  localparam int DATA_W = DATA_WIDTH_DEF;
  localparam int HDR_W  = HDR_WIDTH_DEF;
  localparam int STRB   = DATA_W / BYTE_BITS;

  // Each row holds one packet's length, header, dest, user, stall pattern and output beat count
  localparam int NUM_ROWS = 16;
  localparam int ROW_LEN [NUM_ROWS] = '{1, 4, 8, 9, 13, 16, 17, 20, 24, 31, 32, 40, 48, 57, 6, 64};
  localparam logic [HDR_W-1:0] ROW_HDR [NUM_ROWS] = '{
    64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210, 64'h0000_0000_0000_0001,
    64'h8000_0000_0000_0000, 64'hdead_beef_cafe_f00d, 64'h1111_2222_3333_4444,
    64'h5555_aaaa_5555_aaaa, 64'h0f0f_f0f0_0f0f_f0f0, 64'h1357_9bdf_2468_ace0,
    64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0000, 64'h7a7a_1c1c_3e3e_5d5d,
    64'h0102_0304_0506_0708, 64'hc001_d00d_feed_face, 64'h4242_4242_4242_4242,
    64'h9e37_79b9_7f4a_7c15
  };
  localparam logic [7:0] ROW_DEST [NUM_ROWS] = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h10, 8'h20,
    8'h30, 8'h40, 8'h55, 8'haa, 8'hff, 8'h00, 8'h7e, 8'h81, 8'h12, 8'h34};
  localparam logic [7:0] ROW_USER [NUM_ROWS] = '{8'hf0, 8'h0f, 8'h3c, 8'hc3, 8'h01, 8'h80,
    8'h11, 8'h22, 8'h33, 8'h44, 8'h99, 8'h66, 8'h00, 8'hff, 8'h5a, 8'ha5};
  localparam logic [7:0] ROW_STALL [NUM_ROWS] = '{8'h00, 8'h00, 8'haa, 8'h0f, 8'h00, 8'hcc,
    8'h81, 8'hfe, 8'h00, 8'h55, 8'hf0, 8'h00, 8'h33, 8'he7, 8'h00, 8'haa};
  localparam int ROW_OUT_BEATS [NUM_ROWS] = '{1, 1, 1, 1, 1, 1, 2, 2, 2, 2, 2, 3, 3, 4, 1, 4};

  logic              clk;
  logic              rst;
  logic [DATA_W-1:0] in_tdata;
  logic [STRB-1:0]   in_tkeep;
  logic [7:0]        in_tdest;
  logic [7:0]        in_tuser;
  logic              in_tlast;
  logic              in_tvalid;
  logic              in_tready;
  logic [HDR_W-1:0]  in_header;
  logic              in_header_valid;
  logic              in_header_ready;
  logic [DATA_W-1:0] out_tdata;
  logic [STRB-1:0]   out_tkeep;
  logic [7:0]        out_tdest;
  logic [7:0]        out_tuser;
  logic              out_tlast;
  logic              out_tvalid;
  logic              out_tready;
  logic [HDR_W-1:0]  out_header;

  int         seed = 87;
  int         error_count = 0;
  int         checks = 0;
  int         pkts_done = 0;
  int         rx_bytes = 0;
  int         rx_beats = 0;
  int         stall_cyc = 0;
  logic       was_rst = 1'b1;
  logic       next_ready = 1'b1;
  logic [7:0] exp_bytes [$];
  int         exp_row [$];

  tb_clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  header_tunnel #(
    .DATA_WIDTH (DATA_W),
    .HDR_WIDTH  (HDR_W),
    .DEST_WIDTH (DEST_WIDTH_DEF),
    .USER_WIDTH (USER_WIDTH_DEF),
    .FIFO_DEPTH (FIFO_DEPTH_DEF)
  ) u_header_tunnel (
    .clk             (clk),
    .rst             (rst),
    .in_tdata        (in_tdata),
    .in_tkeep        (in_tkeep),
    .in_tdest        (in_tdest),
    .in_tuser        (in_tuser),
    .in_tlast        (in_tlast),
    .in_tvalid       (in_tvalid),
    .in_tready       (in_tready),
    .in_header       (in_header),
    .in_header_valid (in_header_valid),
    .in_header_ready (in_header_ready),
    .out_tdata       (out_tdata),
    .out_tkeep       (out_tkeep),
    .out_tdest       (out_tdest),
    .out_tuser       (out_tuser),
    .out_tlast       (out_tlast),
    .out_tvalid      (out_tvalid),
    .out_tready      (out_tready),
    .out_header      (out_header)
  );

  task automatic check_value(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  // Values are stable at the falling edge and transfer on the next rising edge
  task automatic wait_transfer(input logic first_beat);
    logic fired;
    fired = 1'b0;
    while (!fired) begin
      @(negedge clk);
      fired = in_tready;
      // The header moves only together with the first beat of its packet
      if (fired) begin
        check_value(in_header_ready, first_beat, "in_header_ready on a transfer");
      end else begin
        check_value(in_header_ready, 1'b0, "in_header_ready while stalled");
      end
      @(posedge clk);
    end
  endtask

  function automatic int table_bytes();
    int sum;
    int k;
    sum = 0;
    for (k = 0; k < NUM_ROWS; k++) begin
      sum += ROW_LEN[k];
    end
    return sum;
  endfunction

  initial begin : stimulus
    int         row;
    int         beat;
    int         nbeats;
    int         b;
    int         lane;
    int         r;
    int         total_errors;
    logic [DATA_W-1:0] data;
    logic [STRB-1:0]   keep;
    logic [7:0] payload [$];
    in_tdata        = '0;
    in_tkeep        = '0;
    in_tdest        = '0;
    in_tuser        = '0;
    in_tlast        = 1'b0;
    in_tvalid       = 1'b0;
    in_header       = '0;
    in_header_valid = 1'b0;
    out_tready      = 1'b0;
    @(negedge rst);
    @(posedge clk);
    for (row = 0; row < NUM_ROWS; row++) begin
      payload.delete();
      for (b = 0; b < ROW_LEN[row]; b++) begin
        r = $random(seed);
        payload.push_back(r[7:0]);
        exp_bytes.push_back(r[7:0]);
      end
      exp_row.push_back(row);
      nbeats = (ROW_LEN[row] + STRB - 1) / STRB;
      for (beat = 0; beat < nbeats; beat++) begin
        data = '0;
        keep = '0;
        for (lane = 0; lane < STRB; lane++) begin
          b = beat * STRB + lane;
          if (b < ROW_LEN[row]) begin
            data[8*lane +: 8] = payload[b];
            keep[lane]        = 1'b1;
          end
        end
        in_tdata        <= data;
        in_tkeep        <= keep;
        in_tdest        <= ROW_DEST[row];
        in_tuser        <= ROW_USER[row];
        in_tlast        <= (beat == nbeats - 1);
        in_tvalid       <= 1'b1;
        in_header       <= ROW_HDR[row];
        in_header_valid <= (beat == 0);
        wait_transfer(beat == 0);
      end
    end
    in_tvalid       <= 1'b0;
    in_tlast        <= 1'b0;
    in_header_valid <= 1'b0;
    while (pkts_done < NUM_ROWS) @(posedge clk);
    // Idle a little so a duplicated beat would still show up
    repeat (10) @(posedge clk);
    check_value(exp_bytes.size(), 0, "expected bytes left over");
    total_errors = error_count + u_header_tunnel.u_tunnel_props.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d, packets: %0d of %0d",
             checks, error_count, u_header_tunnel.u_tunnel_props.fail_count,
             pkts_done, NUM_ROWS);
    if (total_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  always @(negedge clk) begin : output_monitor
    int              row;
    int              remaining;
    int              lanes;
    int              i;
    int              r;
    logic [STRB-1:0] keep_exp;
    if (rst || was_rst) begin
      check_value(out_tvalid, 1'b0, "out_tvalid around reset");
    end
    was_rst = rst;
    if (!rst && out_tvalid && out_tready) begin
      if (exp_row.size() == 0) begin
        $display("Output beat at %0t ns arrived with no packet outstanding", $time);
        error_count++;
      end else begin
        row       = exp_row[0];
        remaining = ROW_LEN[row] - rx_bytes;
        lanes     = (remaining > STRB) ? STRB : remaining;
        keep_exp  = '0;
        for (i = 0; i < lanes; i++) begin
          keep_exp[i] = 1'b1;
          check_value(out_tdata[8*i +: 8], exp_bytes.pop_front(), "payload byte");
        end
        check_value(out_tkeep, keep_exp, "out_tkeep");
        check_value(out_tlast, remaining <= STRB, "out_tlast");
        check_value(out_header, ROW_HDR[row], "out_header");
        check_value(out_tdest, ROW_DEST[row], "out_tdest");
        check_value(out_tuser, ROW_USER[row], "out_tuser");
        rx_bytes += lanes;
        rx_beats++;
        // The DUT's own tlast closes the packet
        if (out_tlast) begin
          check_value(rx_beats, ROW_OUT_BEATS[row], "output beats in packet");
          void'(exp_row.pop_front());
          rx_bytes = 0;
          rx_beats = 0;
          pkts_done++;
        end
      end
    end
    // The packet at the head of the queue picks the stall pattern
    row        = (exp_row.size() != 0) ? exp_row[0] : 0;
    r          = $random(seed);
    next_ready = !(ROW_STALL[row][stall_cyc % 8] || (r[2:0] == 3'd0));
    stall_cyc++;
  end

  always @(posedge clk) begin
    out_tready <= next_ready;
  end

  initial begin : watchdog
    int limit;
    limit = table_bytes() / STRB * 20 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: only %0d of %0d packets came out within %0d cycles",
             pkts_done, NUM_ROWS, limit);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== header_tunnel.f ====
common/tunnel_pkg.sv
header_adder/header_adder.sv
header_remover/header_remover.sv
source/stream_fifo.sv
source/header_tunnel.sv
sim/tb_clock_gen.sv
sim/header_tunnel_properties.sv
sim/header_tunnel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module header_tunnel_tb \
  -f header_tunnel.f -o header_tunnel_sim || exit 1
sim_output=$(./obj_dir/header_tunnel_sim)
echo "$sim_output"
echo "$sim_output" | grep -q "^Verification passed$" && exit 0 || exit 1
